//--- list.f
+incdir+.
chase_pkg.sv
du_pkg.sv
du_lane_if.sv
du_delay_line.sv
du_flip_table.sv
du_prior_select.sv
decision_unit.sv
tb_decision_unit.sv

//--- Bender.yml
package:
  name: decision_unit

export_include_dirs:
  - .

sources:
  - chase_pkg.sv
  - du_pkg.sv
  - du_lane_if.sv
  - du_delay_line.sv
  - du_flip_table.sv
  - du_prior_select.sv
  - decision_unit.sv
  - target: test
    files:
      - tb_decision_unit.sv

//--- decision_unit_testdata.txt
// columns: sel, alpha_loc, hd_err_loc, expected out_err_loc, all hex
// the hd_err_loc of a line meets the sel and alpha_loc of the line 8 lines later
01 F59 0FF03CA5 0
02 F59 FFFFFFFF A
04 2A7 00000000 C
08 CEA 12345678 1
10 FFF 80402010 0
20 531 DEADBEEF 6
40 F59 01020408 3
80 2A7 AA55AA55 9
01 CEA C3C3C3C3 9
03 FFF 0000FFFF F
00 F59 FF00FF00 0
06 2A7 13579BDF F
0C CEA 87654321 B
F8 531 F0F0F0F0 2
30 F59 5A5A5A5A 6
E0 2A7 E7E7E7E7 9
40 CEA 11111111 3
80 FFF 22222222 C
00 531 44444444 0
FF 000 88888888 F
0A 000 FEDCBA98 A
24 FFF 76543210 0
08 F59 00FF00FF 6
90 2A7 A5A5A5A5 6
20 CEA 3C3C3C3C A
C0 531 69696969 7
80 F59 96969696 F
02 2A7 CAFEF00D 5

//--- tb_decision_unit.sv
`timescale 1ns/1ps
`include "du_macros.svh"

module tb_decision_unit
    import chase_pkg::*, du_pkg::*;
();

    localparam int    MAX_VECTORS = 64;
    localparam string DATA_FILE   = "decision_unit_testdata.txt";

    logic        clk;
    logic        rst;
    logic        in_valid;
    tp_vec_t     in_sel;
    lane_alpha_t in_alpha_loc;
    lane_tp_t    in_hd_err_loc;
    logic        out_valid;
    err_loc_t    out_err_loc;

    logic [31:0] vec_mem [0:4*MAX_VECTORS-1]; // four words per line.
    int          num_vectors = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          test_checks0;
    int          test_errors0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] rng_state = 32'h3a92b675;
    logic        prev_strobe = 1'b0; // strobe driven on the last step.
    err_loc_t    prev_exp = '0;
    err_loc_t    last_expected = '0; // what out_err_loc should hold.

    decision_unit decision_unit_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_sel        (in_sel),
        .in_alpha_loc  (in_alpha_loc),
        .in_hd_err_loc (in_hd_err_loc),
        .out_valid     (out_valid),
        .out_err_loc   (out_err_loc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // outputs seen at a falling edge belong to the step driven one cycle earlier.
    task automatic check_outputs();
        if (prev_strobe) begin
            compare("out_valid after strobe", 32'(out_valid), 32'd1);
            compare("out_err_loc", 32'(out_err_loc), 32'(prev_exp));
            last_expected = prev_exp;
        end else begin
            compare("out_valid without strobe", 32'(out_valid), 32'd0);
            compare("out_err_loc held", 32'(out_err_loc), 32'(last_expected));
        end
    endtask

    // idle cycle with junk on the data inputs.
    task automatic idle_step();
        @(negedge clk);
        check_outputs();
        rng_state     = lcg_next(rng_state);
        in_valid      = 1'b0;
        in_sel        = rng_state[7:0];
        in_alpha_loc  = rng_state[27:16];
        in_hd_err_loc = ~rng_state;
        prev_strobe   = 1'b0;
    endtask

    task automatic strobe_step(input int idx);
        @(negedge clk);
        check_outputs();
        in_valid      = 1'b1;
        in_sel        = vec_mem[4*idx][7:0];
        in_alpha_loc  = vec_mem[4*idx+1][11:0];
        in_hd_err_loc = vec_mem[4*idx+2];
        prev_strobe   = 1'b1;
        prev_exp      = vec_mem[4*idx+3][3:0];
    endtask

    // 0 to 3 idle cycles, then the beat.
    task automatic run_vector(input int idx);
        int unsigned gap;

        rng_state = lcg_next(rng_state);
        gap = rng_state[17:16];
        repeat (gap) idle_step();
        strobe_step(idx);
    endtask

    task automatic start_test();
        test_checks0 = check_count;
        test_errors0 = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %s done: %0d checks, %0d errors", name,
                 check_count - test_checks0, error_count - test_errors0);
    endtask

    task automatic run_all();
        int fill_end;

        fill_end = (num_vectors < `DU_DELAY_BEATS) ? num_vectors : `DU_DELAY_BEATS;

        start_test();
        repeat (3) idle_step();
        finish_test("reset");

        // delayed hard beats are still zero here.
        start_test();
        for (int i = 0; i < fill_end; i++) begin
            run_vector(i);
        end
        idle_step();
        finish_test("fill");

        start_test();
        for (int i = fill_end; i < num_vectors; i++) begin
            run_vector(i);
        end
        idle_step();
        finish_test("steady");

        start_test();
        repeat (3) idle_step();
        finish_test("drain");
    endtask

    initial begin
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_sel        = '0;
        in_alpha_loc  = '0;
        in_hd_err_loc = '0;

        $readmemh(DATA_FILE, vec_mem);
        while (num_vectors < MAX_VECTORS && !$isunknown(vec_mem[4*num_vectors])) begin
            num_vectors++;
        end
        cycle_limit = num_vectors * 5 + 20;

        if (num_vectors == 0) begin
            $display("no test vectors could be read from %s", DATA_FILE);
            $display("Result: FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            run_all();
            $display("summary: %0d tests, %0d vectors, %0d checks, %0d errors",
                     test_count, num_vectors, check_count, error_count);
            if (error_count == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

//--- decision_unit.sv
`timescale 1ns/1ps
`include "du_macros.svh"

// decision stage of the chase decoder, fifo-channel mode.
// hard-decision bits arrive DU_DELAY_BEATS strobes ahead of the
// alpha-location bits they belong to.
module decision_unit
    import chase_pkg::*, du_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  tp_vec_t     in_sel,
    input  lane_alpha_t in_alpha_loc,
    input  lane_tp_t    in_hd_err_loc,
    output logic        out_valid,
    output err_loc_t    out_err_loc
);

    du_lane_if lane_if ();

    du_delay_line #(
        .DEPTH (`DU_DELAY_BEATS)
    ) delay_line_i (
        .clk   (clk),
        .rst   (rst),
        .valid (in_valid),
        .din   (in_hd_err_loc),
        .lane  (lane_if.hd_src)
    );

    du_flip_table flip_table_i (
        .valid (in_valid),
        .sel   (in_sel),
        .alpha (in_alpha_loc),
        .lane  (lane_if.sd_src)
    );

    // one cycle from strobe to out_valid.
    du_prior_select prior_select_i (
        .clk         (clk),
        .rst         (rst),
        .lane        (lane_if.sink),
        .out_valid   (out_valid),
        .out_err_loc (out_err_loc)
    );

endmodule

//--- du_prior_select.sv
`timescale 1ns/1ps
`include "du_macros.svh"

// picks the test pattern named by the lowest set bit of sel, per lane,
// and registers hard xor soft of that pattern. a zero sel selects the
// default input, which gives a zero result.
module du_prior_select
    import chase_pkg::*, du_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    du_lane_if.sink   lane,
    output logic      out_valid,
    output err_loc_t  out_err_loc
);

    tp_vec_t  first_hot; // lowest set bit of sel, one-hot.
    err_loc_t result;

    // two's complement trick isolates the lowest set bit.
    assign first_hot = lane.sel & (~lane.sel + tp_vec_t'(1));

    always_comb begin
        tp_vec_t combined;

        result = '0;
        for (int j = 0; j < `DU_PARALLELISM; j++) begin
            combined  = lane.hd_pat[j] ^ lane.sd_pat[j];
            result[j] = |(combined & first_hot); // zero when sel is zero.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_err_loc <= '0;
        end else begin
            out_valid <= lane.valid;
            if (lane.valid) begin
                out_err_loc <= result; // hold until next beat.
            end
        end
    end

    // sel comes from the flip-table side of the interface.
    a_sel_known: assert property (
        @(posedge clk) disable iff (rst)
        lane.valid |-> !$isunknown(lane.sel)
    ) else $error("du_prior_select: unknown bits in sel");

endmodule

//--- du_flip_table.sv
`timescale 1ns/1ps
`include "du_macros.svh"

// soft-decision flip bits for every test pattern.
// each pattern flips a fixed subset of the least reliable bits,
// so its flip bit at a position is the xor of the alpha-location
// bits in that subset.
module du_flip_table
    import chase_pkg::*, du_pkg::*;
(
    input  logic        valid,
    input  tp_vec_t     sel,
    input  lane_alpha_t alpha,
    du_lane_if.sd_src   lane
);

    lane_tp_t flip;

    always_comb begin
        alpha_loc_t a;

        flip = '0;
        for (int j = 0; j < `DU_PARALLELISM; j++) begin
            a = alpha[j];
            flip[j][0] = 1'b0;                 // no flip.
            flip[j][1] = a[1];
            flip[j][2] = a[0] ^ a[1];
            flip[j][3] = a[0] ^ a[1] ^ a[2];   // all three.
            flip[j][4] = a[1] ^ a[2];
            flip[j][5] = a[2];
            flip[j][6] = a[0] ^ a[2];
            flip[j][7] = a[0];
        end
    end

    // strobe and select leave with the flip bits as one group.
    assign lane.valid  = valid;
    assign lane.sel    = sel;
    assign lane.sd_pat = flip;

endmodule

//--- du_delay_line.sv
`timescale 1ns/1ps
`include "du_macros.svh"

// holds hard-decision error-location beats until the matching
// alpha-location beat arrives. the line only moves on a strobe,
// so the delay is counted in beats and idle cycles are free.
module du_delay_line
    import chase_pkg::*, du_pkg::*;
#(
    parameter int unsigned DEPTH = `DU_DELAY_BEATS
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid,
    input  lane_tp_t        din,
    du_lane_if.hd_src       lane
);

    lane_tp_t stage_q [DEPTH]; // stage 0 is the newest beat.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= {`DU_PARALLELISM{tp_vec_t'(0)}}; // zero pattern in every lane.
            end
        end else if (valid) begin
            stage_q[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1]; // advance one place.
            end
        end
    end

    // oldest beat, entered DEPTH strobes ago.
    assign lane.hd_pat = stage_q[DEPTH-1];

    // an X taken in here would surface DEPTH beats later in the output.
    a_din_known: assert property (
        @(posedge clk) disable iff (rst)
        valid |-> !$isunknown(din)
    ) else $error("du_delay_line: unknown bits in hard beat");

endmodule

//--- du_lane_if.sv
`timescale 1ns/1ps

// one aligned beat on its way into the selector.
// hard bits come from the delay line, the rest from the flip table.
interface du_lane_if;

    logic              valid;  // beat strobe.
    chase_pkg::tp_vec_t sel;   // test-pattern select vector.
    du_pkg::lane_tp_t  hd_pat; // delayed hard-decision bits.
    du_pkg::lane_tp_t  sd_pat; // soft-decision flip bits.

    modport hd_src (
        output hd_pat
    );

    modport sd_src (
        output valid,
        output sel,
        output sd_pat
    );

    modport sink (
        input valid,
        input sel,
        input hd_pat,
        input sd_pat
    );

endinterface

//--- du_pkg.sv
`include "du_macros.svh"

// datapath types of the decision unit.
// one beat carries DU_PARALLELISM positions side by side,
// lane 0 in the low bits.
package du_pkg;

    import chase_pkg::*;

    // hard or soft pattern bits of a whole beat.
    typedef tp_vec_t [`DU_PARALLELISM-1:0] lane_tp_t;

    // alpha-location bits of a whole beat.
    typedef alpha_loc_t [`DU_PARALLELISM-1:0] lane_alpha_t;

    // final error-location flag, one bit per position.
    typedef logic [`DU_PARALLELISM-1:0] err_loc_t;

endpackage

//--- chase_pkg.sv
`include "du_macros.svh"

// code-side types of the chase decoder.
// these describe one codeword position, independent of how many
// positions the datapath handles per beat.
package chase_pkg;

    // alpha-location bits of one position.
    // bit 0 is a0, bit 1 is a1, bit 2 is a2 in the flip table.
    typedef logic [`DU_SD_CORRECTABLE-1:0] alpha_loc_t;

    // one bit per test pattern.
    // used as the select vector, where the lowest set bit wins,
    // and as the hard or soft pattern bits of a single position.
    typedef logic [`DU_TP_NUMS-1:0] tp_vec_t;

endpackage

//--- du_macros.svh
`ifndef DU_MACROS_SVH
`define DU_MACROS_SVH

// codeword positions carried by one beat.
`define DU_PARALLELISM 4

// alpha-location bits per position.
`define DU_SD_CORRECTABLE 3

// number of test patterns, 2 ** DU_SD_CORRECTABLE.
`define DU_TP_NUMS (1 << `DU_SD_CORRECTABLE)

// hard-decision delay in strobes, kept short for simulation.
// a full codeword would need codeword length over parallelism.
`define DU_DELAY_BEATS 8

`endif
